//--- build.f
design/cpu_pkg.sv
design/pipeline_ctrl.sv
design/fetch.sv
design/reg_file.sv
design/execute.sv
design/data_mem.sv
design/cpu.sv
tests/tb_clock.sv
tests/cpu_tb.sv

//--- tests/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

  localparam int CLK_NS       = 8;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_CYCLES   = 300;
  localparam int PROGRAM_RUNS = 7;
  localparam int TEST_CYCLES  = cpu_pkg::IMEM_DEPTH + RESET_CYCLES + RUN_CYCLES + 48;
  localparam int TIMEOUT_NS   = PROGRAM_RUNS * TEST_CYCLES * CLK_NS;

  wire                 clk;
  logic                rst_i;
  logic                imem_we_i;
  cpu_pkg::imem_addr_t imem_addr_i;
  cpu_pkg::word_t      imem_data_i;
  cpu_pkg::reg_addr_t  dbg_addr_i;
  cpu_pkg::word_t      dbg_data_o;
  cpu_pkg::flags_t     flags_o;

  cpu_pkg::word_t  prog [cpu_pkg::IMEM_DEPTH];
  int              prog_len;
  cpu_pkg::word_t  m_regs [16];  // reference model state
  cpu_pkg::word_t  m_mem [cpu_pkg::DMEM_DEPTH];
  cpu_pkg::flags_t m_flags;
  logic [31:0]     lfsr = 32'h741c_1ccf;

  tb_clock clk_gen_inst (.clk_o(clk));

  cpu cpu_inst (
    .clk(clk), .rst_i(rst_i),
    .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
    .dbg_addr_i(dbg_addr_i), .dbg_data_o(dbg_data_o), .flags_o(flags_o)
  );

  // ****************************************
  // instruction encoders
  // ****************************************
  function automatic cpu_pkg::word_t dp_imm(input logic [3:0] cond, input logic [3:0] op,
      input logic s, input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rn,
      input logic [3:0] rot, input logic [7:0] imm);
    return {cond, cpu_pkg::CLS_DP_IMM, op, s, rn, rd, rot, imm};
  endfunction

  function automatic cpu_pkg::word_t dp_reg(input logic [3:0] cond, input logic [3:0] op,
      input logic s, input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rn,
      input cpu_pkg::reg_addr_t rm);
    return {cond, cpu_pkg::CLS_DP_REG, op, s, rn, rd, 8'd0, rm};  // shift of zero
  endfunction

  function automatic cpu_pkg::word_t mem_op(input logic load, input logic up,
      input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rn, input logic [11:0] off);
    return {cpu_pkg::COND_AL, cpu_pkg::CLS_MEM, 1'b1, up, 2'b00, load, rn, rd, off};
  endfunction

  function automatic cpu_pkg::word_t branch_op(input logic [3:0] cond, input logic link,
      input logic [23:0] off);
    return {cond, cpu_pkg::CLS_BRANCH, link, off};
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check(input cpu_pkg::word_t got, input cpu_pkg::word_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic read_reg(input cpu_pkg::reg_addr_t r, output cpu_pkg::word_t v);
    @(posedge clk);
    #1;
    dbg_addr_i = r;
    #1;
    v = dbg_data_o;
  endtask

  task automatic check_reg(input cpu_pkg::reg_addr_t r, input cpu_pkg::word_t exp,
      input string what);
    cpu_pkg::word_t got;
    read_reg(r, got);
    check(got, exp, what);
  endtask

  task automatic emit(input cpu_pkg::word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic new_program();
    int a;
    for (a = 0; a < cpu_pkg::IMEM_DEPTH; a++) begin
      prog[a] = 32'hF000_0000 | a;  // never-condition filler, unique per address
    end
    prog_len = 0;
  endtask

  // ****************************************
  // reference model
  // ****************************************
  task automatic model_exec(input cpu_pkg::word_t inst);
    cpu_pkg::word_t  op1;
    cpu_pkg::word_t  op2;
    cpu_pkg::word_t  res;
    cpu_pkg::word_t  addr;
    cpu_pkg::flags_t nf;
    logic [3:0]      op;
    int              sh;
    op1 = m_regs[inst[19:16]];
    op  = inst[24:21];
    nf  = m_flags;
    if (inst[27:25] == cpu_pkg::CLS_MEM) begin
      addr = inst[23] ? op1 + inst[11:0] : op1 - inst[11:0];
      if (inst[20]) begin
        m_regs[inst[15:12]] = m_mem[addr[7:2]];
      end else begin
        m_mem[addr[7:2]] = m_regs[inst[15:12]];
      end
    end else begin
      sh  = 2 * inst[11:8];
      op2 = (inst[27:25] == cpu_pkg::CLS_DP_IMM) ?
            (({24'd0, inst[7:0]} >> sh) | ({24'd0, inst[7:0]} << (32 - sh))) :
            m_regs[inst[3:0]];
      case (op)
        cpu_pkg::OP_AND: res = op1 & op2;
        cpu_pkg::OP_EOR: res = op1 ^ op2;
        cpu_pkg::OP_ORR: res = op1 | op2;
        cpu_pkg::OP_ADD: begin
          res  = op1 + op2;
          nf.c = (res < op1);  // unsigned wrap
          nf.v = (op1[31] == op2[31]) && (res[31] != op1[31]);
        end
        cpu_pkg::OP_SUB, cpu_pkg::OP_CMP: begin
          res  = op1 - op2;
          nf.c = (op1 >= op2);
          nf.v = (op1[31] != op2[31]) && (res[31] != op1[31]);
        end
        default: res = op2;  // mov
      endcase
      nf.n = res[31];
      nf.z = (res == 0);
      if (inst[20] || op == cpu_pkg::OP_CMP) m_flags = nf;
      if (op != cpu_pkg::OP_CMP) m_regs[inst[15:12]] = res;
    end
  endtask

  task automatic run_model();
    cpu_pkg::word_t pc;
    cpu_pkg::word_t inst;
    cpu_pkg::word_t target;
    logic           ok;
    int             off;
    int             steps;
    int             r;
    pc      = '0;
    m_flags = '0;
    for (r = 0; r < 16; r++) begin
      m_regs[r] = '0;
    end
    for (steps = 0; steps < 256; steps++) begin
      inst = prog[pc[7:2]];
      case (inst[31:28])
        cpu_pkg::COND_EQ: ok = m_flags.z;
        cpu_pkg::COND_NE: ok = !m_flags.z;
        cpu_pkg::COND_AL: ok = 1'b1;
        default:          ok = 1'b0;
      endcase
      off    = $signed(inst[23:0]);  // signed word offset
      target = pc + 32'd8 + 4 * off;
      if (ok && inst[27:25] == cpu_pkg::CLS_BRANCH) begin
        if (inst[24]) m_regs[14] = pc + 32'd4;
        if (target == pc) break;  // reached the halt loop
        pc = target;
      end else begin
        if (ok) model_exec(inst);
        pc = pc + 32'd4;
      end
    end
  endtask

  task automatic compare_state(input string name);
    cpu_pkg::word_t got;
    int             r;
    for (r = 0; r < 16; r++) begin
      read_reg(cpu_pkg::reg_addr_t'(r), got);
      check(got, m_regs[r], $sformatf("%s r%0d", name, r));
    end
    check({28'd0, flags_o}, {28'd0, m_flags}, {name, " flags"});
  endtask

  // load with the core in reset, then let it run to the halt loop
  task automatic run_program(input string name);
    int a;
    emit(branch_op(cpu_pkg::COND_AL, 1'b0, 24'hFF_FFFE));
    @(posedge clk);
    #1;
    rst_i = 1'b1;
    for (a = 0; a < cpu_pkg::IMEM_DEPTH; a++) begin
      imem_we_i   = 1'b1;
      imem_addr_i = cpu_pkg::imem_addr_t'(a);
      imem_data_i = prog[a];
      @(posedge clk);
      #1;
    end
    imem_we_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_i = 1'b0;
    run_model();
    repeat (RUN_CYCLES) @(posedge clk);
    #1;
    compare_state(name);
  endtask

  // ****************************************
  // directed tests
  // ****************************************
  task automatic mov_add_immediates();
    new_program();
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd1, 4'd0, 4'd4, 8'hFF));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd2, 4'd0, 4'd14, 8'h3F));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_ADD, 1'b1, 4'd3, 4'd1, 4'd1, 8'hAB));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_ADD, 1'b0, 4'd4, 4'd2, 4'd0, 8'h10));
    run_program("immediates");
    check_reg(4'd1, 32'hFF00_0000, "mov ror 8");
    check_reg(4'd2, 32'h0000_03F0, "mov ror 28");
    check_reg(4'd3, 32'hBF00_002A, "adds ror 2");
    check_reg(4'd4, 32'h0000_0400, "add unrotated");
    check({28'd0, flags_o}, 32'h0000_000A, "adds flags");  // n and c set
  endtask

  task automatic dependent_reg_chain();
    new_program();
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd1, 4'd0, 4'd0, 8'h5A));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd2, 4'd0, 4'd8, 8'hFF));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_ORR, 1'b0, 4'd3, 4'd2, 4'd1));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_AND, 1'b0, 4'd4, 4'd3, 4'd1));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_EOR, 1'b0, 4'd5, 4'd4, 4'd3));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_SUB, 1'b0, 4'd6, 4'd5, 4'd1));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_SUB, 1'b1, 4'd7, 4'd1, 4'd6));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_ORR, 1'b0, 4'd8, 4'd7, 4'd7));
    run_program("register chain");
    check_reg(4'd3, 32'h00FF_005A, "orr result");
    check_reg(4'd5, 32'h00FF_0000, "eor result");
  endtask

  task automatic compare_and_branch();
    // unequal compare on its own, 5 - 7 borrows
    new_program();
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd1, 4'd0, 4'd0, 8'd5));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd3, 4'd0, 4'd0, 8'd7));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_CMP, 1'b1, 4'd0, 4'd1, 4'd3));
    run_program("unequal compare");
    check({28'd0, flags_o}, 32'h0000_0008, "cmp unequal flags");  // n set, c clear

    new_program();
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd1, 4'd0, 4'd0, 8'd5));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd2, 4'd0, 4'd0, 8'd5));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd3, 4'd0, 4'd0, 8'd7));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_CMP, 1'b1, 4'd0, 4'd1, 4'd2));
    emit(branch_op(cpu_pkg::COND_EQ, 1'b0, 24'd1));  // taken, skips two
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd4, 4'd0, 4'd0, 8'd1));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd5, 4'd0, 4'd0, 8'd1));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd6, 4'd0, 4'd0, 8'd2));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_CMP, 1'b1, 4'd0, 4'd1, 4'd3));
    emit(branch_op(cpu_pkg::COND_EQ, 1'b0, 24'd0));  // not taken
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd7, 4'd0, 4'd0, 8'd3));
    emit(branch_op(cpu_pkg::COND_NE, 1'b0, 24'd0));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd9, 4'd0, 4'd0, 8'd9));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd10, 4'd0, 4'd0, 8'd10));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_CMP, 1'b1, 4'd0, 4'd3, 4'd0, 8'd7));
    emit(dp_imm(cpu_pkg::COND_EQ, cpu_pkg::OP_MOV, 1'b0, 4'd12, 4'd0, 4'd0, 8'd12));
    emit(dp_imm(cpu_pkg::COND_NE, cpu_pkg::OP_MOV, 1'b0, 4'd13, 4'd0, 4'd0, 8'd13));
    run_program("compare and branch");
    check_reg(4'd4, 32'd0, "skipped after beq");
    check_reg(4'd9, 32'd0, "skipped after bne");
    check_reg(4'd12, 32'd12, "moveq");
    check_reg(4'd13, 32'd0, "movne");
    check({28'd0, flags_o}, 32'h0000_0006, "cmp equal flags");
  endtask

  task automatic store_then_load();
    new_program();
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd1, 4'd0, 4'd0, 8'h40));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd2, 4'd0, 4'd2, 8'hA5));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd3, 4'd0, 4'd1, 8'h7E));
    emit(mem_op(1'b0, 1'b1, 4'd2, 4'd1, 12'd8));
    emit(mem_op(1'b0, 1'b0, 4'd3, 4'd1, 12'd16));  // offset down
    emit(mem_op(1'b1, 1'b1, 4'd4, 4'd1, 12'd8));
    emit(mem_op(1'b1, 1'b0, 4'd5, 4'd1, 12'd16));
    emit(dp_reg(cpu_pkg::COND_AL, cpu_pkg::OP_ADD, 1'b0, 4'd6, 4'd4, 4'd5));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd7, 4'd0, 4'd0, 8'h33));
    emit(mem_op(1'b0, 1'b1, 4'd7, 4'd1, 12'h020));
    emit(mem_op(1'b1, 1'b1, 4'd8, 4'd1, 12'h020));
    run_program("store and load");
    check_reg(4'd4, 32'h5000_000A, "load with offset up");
    check_reg(4'd5, 32'h8000_001F, "load with offset down");
    check_reg(4'd8, 32'h0000_0033, "load after store");
  endtask

  task automatic branch_and_link();
    new_program();
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd1, 4'd0, 4'd0, 8'd1));
    emit(branch_op(cpu_pkg::COND_AL, 1'b1, 24'd2));  // bl at address 4
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd2, 4'd0, 4'd0, 8'd2));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd3, 4'd0, 4'd0, 8'd3));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_MOV, 1'b0, 4'd4, 4'd0, 4'd0, 8'd4));
    emit(dp_imm(cpu_pkg::COND_AL, cpu_pkg::OP_ADD, 1'b0, 4'd5, 4'd14, 4'd0, 8'h10));
    run_program("branch and link");
    check_reg(4'd14, 32'd8, "link register");
    check_reg(4'd2, 32'd0, "first discarded");
    check_reg(4'd3, 32'd0, "second discarded");
    check_reg(4'd5, 32'h0000_0018, "add at target");
  endtask

  task automatic random_imm_chain();
    logic [31:0] op_bit;
    logic [31:0] s_bit;
    logic [31:0] rd_bits;
    logic [31:0] rn_bits;
    logic [31:0] rot;
    logic [31:0] imm;
    int          i;
    new_program();
    for (i = 0; i < 16; i++) begin
      take_bits(1, op_bit);
      take_bits(1, s_bit);
      take_bits(2, rd_bits);
      take_bits(2, rn_bits);  // r1 to r4 so the chain depends on itself
      take_bits(4, rot);
      take_bits(8, imm);
      emit(dp_imm(cpu_pkg::COND_AL, op_bit[0] ? cpu_pkg::OP_ADD : cpu_pkg::OP_EOR, s_bit[0],
                  4'd1 + rd_bits[3:0], 4'd1 + rn_bits[3:0], rot[3:0], imm[7:0]));
    end
    run_program("random chain");
  endtask

  initial begin
    rst_i       = 1'b1;
    imem_we_i   = 1'b0;
    imem_addr_i = '0;
    imem_data_i = '0;
    dbg_addr_i  = '0;
    mov_add_immediates();
    dependent_reg_chain();
    compare_and_branch();
    store_then_load();
    branch_and_link();
    random_imm_chain();
    $display("All tests passed");
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Error: the run timed out before all tests finished");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_o
);

  localparam real HALF_PERIOD_NS = 4.0;  // 8 ns period

  initial begin
    clk_o = 1'b0;
  end

  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- design/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu (
  input  wire                      clk,
  input  wire                      rst_i,
  input  wire                      imem_we_i,
  input  wire cpu_pkg::imem_addr_t imem_addr_i,
  input  wire cpu_pkg::word_t      imem_data_i,
  input  wire cpu_pkg::reg_addr_t  dbg_addr_i,
  output cpu_pkg::word_t           dbg_data_o,
  output cpu_pkg::flags_t          flags_o
);

  cpu_pkg::if_id_t     if_id;
  cpu_pkg::id_ex_t     id_ex_next;
  cpu_pkg::id_ex_t     id_ex;
  cpu_pkg::ex_wb_t     ex_wb;
  logic                stall;
  logic                flush;
  logic                branch;
  cpu_pkg::word_t      target;
  logic [2:0]          dec_cls;
  logic                dec_store;
  cpu_pkg::reg_addr_t  src_a;
  cpu_pkg::reg_addr_t  src_b;
  logic                src_b_used;
  cpu_pkg::word_t      rdata_a;
  cpu_pkg::word_t      rdata_b;
  cpu_pkg::reg_addr_t  ex_dest;
  logic                ex_writes;
  logic                dmem_we;
  cpu_pkg::dmem_addr_t dmem_addr;
  cpu_pkg::word_t      dmem_wdata;
  cpu_pkg::word_t      dmem_rdata;
  logic                wb_we;
  cpu_pkg::word_t      wb_data;

  // ****************************************
  // decode field split
  // ****************************************
  assign dec_cls    = if_id.inst[cpu_pkg::CLS_LSB +: 3];
  assign dec_store  = (dec_cls == cpu_pkg::CLS_MEM) && !if_id.inst[cpu_pkg::L_BIT];
  assign src_a      = if_id.inst[cpu_pkg::RN_LSB +: 4];
  assign src_b      = dec_store ? if_id.inst[cpu_pkg::RD_LSB +: 4]  // str data comes from rd
                                : if_id.inst[cpu_pkg::RM_LSB +: 4];
  assign src_b_used = dec_store || (dec_cls == cpu_pkg::CLS_DP_REG);

  assign id_ex_next = '{valid: if_id.valid, pc: if_id.pc, inst: if_id.inst,
                        rn_val: rdata_a, rm_val: rdata_b};

  // loads take their data straight from the memory output
  assign wb_we   = ex_wb.valid && ex_wb.wb_en;
  assign wb_data = ex_wb.is_load ? dmem_rdata : ex_wb.data;

  pipeline_ctrl ctrl_inst (
    .clk(clk), .rst_i(rst_i),
    .if_id_i(if_id), .id_ex_next_i(id_ex_next),
    .ex_dest_i(ex_dest), .ex_writes_i(ex_writes),
    .src_a_i(src_a), .src_b_i(src_b), .src_b_used_i(src_b_used),
    .branch_i(branch), .stall_o(stall), .flush_o(flush), .id_ex_o(id_ex)
  );

  fetch fetch_inst (
    .clk(clk), .rst_i(rst_i),
    .stall_i(stall), .flush_i(flush), .branch_i(branch), .target_i(target),
    .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
    .if_id_o(if_id)
  );

  reg_file rf_inst (
    .clk(clk), .rst_i(rst_i),
    .ra_i(src_a), .rb_i(src_b), .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
    .dbg_addr_i(dbg_addr_i), .dbg_data_o(dbg_data_o),
    .we_i(wb_we), .wa_i(ex_wb.rd), .wd_i(wb_data)
  );

  execute ex_inst (
    .clk(clk), .rst_i(rst_i), .id_ex_i(id_ex),
    .branch_o(branch), .target_o(target),
    .mem_we_o(dmem_we), .mem_addr_o(dmem_addr), .mem_wdata_o(dmem_wdata),
    .ex_dest_o(ex_dest), .ex_writes_o(ex_writes),
    .ex_wb_o(ex_wb), .flags_o(flags_o)
  );

  data_mem dmem_inst (
    .clk(clk), .we_i(dmem_we), .addr_i(dmem_addr),
    .wdata_i(dmem_wdata), .rdata_o(dmem_rdata)
  );

endmodule

`default_nettype wire

//--- design/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem (
  input  wire                      clk,
  input  wire                      we_i,
  input  wire cpu_pkg::dmem_addr_t addr_i,
  input  wire cpu_pkg::word_t      wdata_i,
  output cpu_pkg::word_t           rdata_o
);

  cpu_pkg::word_t mem [cpu_pkg::DMEM_DEPTH];

  // ****************************************
  // one port, registered read
  // ****************************************
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // read data lands in the writeback cycle
  always_ff @(posedge clk) begin
    rdata_o <= mem[addr_i];  // old word on a same-cycle write
  end

endmodule

`default_nettype wire

//--- design/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute (
  input  wire                  clk,
  input  wire                  rst_i,
  input  wire cpu_pkg::id_ex_t id_ex_i,
  output logic                 branch_o,
  output cpu_pkg::word_t       target_o,
  output logic                 mem_we_o,
  output cpu_pkg::dmem_addr_t  mem_addr_o,
  output cpu_pkg::word_t       mem_wdata_o,
  output cpu_pkg::reg_addr_t   ex_dest_o,
  output logic                 ex_writes_o,
  output cpu_pkg::ex_wb_t      ex_wb_o,
  output cpu_pkg::flags_t      flags_o
);

  cpu_pkg::flags_t flags_r;
  cpu_pkg::flags_t flags_n;
  logic [3:0]      cond;
  logic [2:0]      cls;
  logic [3:0]      opcode;
  logic            is_dp;
  logic            is_mem;
  logic            is_br;
  logic            is_ldr;
  logic            cond_ok;
  logic            fire;
  logic            set_flags;
  logic            writes;
  logic [4:0]      rot_amt;
  logic [63:0]     imm_dbl;
  cpu_pkg::word_t  op1;
  cpu_pkg::word_t  op2;
  cpu_pkg::word_t  alu_res;
  cpu_pkg::word_t  mem_addr_full;
  cpu_pkg::word_t  link_addr;
  logic [32:0]     sum;
  logic [32:0]     diff;

  assign cond   = id_ex_i.inst[cpu_pkg::COND_LSB +: 4];
  assign cls    = id_ex_i.inst[cpu_pkg::CLS_LSB +: 3];
  assign opcode = id_ex_i.inst[cpu_pkg::OP_LSB +: 4];
  assign is_dp  = (cls == cpu_pkg::CLS_DP_REG) || (cls == cpu_pkg::CLS_DP_IMM);
  assign is_mem = (cls == cpu_pkg::CLS_MEM);
  assign is_br  = (cls == cpu_pkg::CLS_BRANCH);
  assign is_ldr = is_mem && id_ex_i.inst[cpu_pkg::L_BIT];

  always_comb begin
    case (cond)
      cpu_pkg::COND_EQ: cond_ok = flags_r.z;
      cpu_pkg::COND_NE: cond_ok = !flags_r.z;
      cpu_pkg::COND_AL: cond_ok = 1'b1;
      default:          cond_ok = 1'b0;  // treated as never
    endcase
  end

  assign fire = id_ex_i.valid && cond_ok;

  // ****************************************
  // operand 2 and alu
  // ****************************************
  assign rot_amt = {id_ex_i.inst[cpu_pkg::ROT_LSB +: 4], 1'b0};
  assign imm_dbl = {24'd0, id_ex_i.inst[7:0], 24'd0, id_ex_i.inst[7:0]} >> rot_amt;
  assign op2     = (cls == cpu_pkg::CLS_DP_IMM) ? imm_dbl[31:0] : id_ex_i.rm_val;
  assign op1     = id_ex_i.rn_val;

  assign sum  = {1'b0, op1} + {1'b0, op2};
  assign diff = {1'b0, op1} + {1'b0, ~op2} + 33'd1;

  always_comb begin
    flags_n = flags_r;  // c and v kept by the logic ops
    case (opcode)
      cpu_pkg::OP_AND: alu_res = op1 & op2;
      cpu_pkg::OP_EOR: alu_res = op1 ^ op2;
      cpu_pkg::OP_ORR: alu_res = op1 | op2;
      cpu_pkg::OP_MOV: alu_res = op2;
      cpu_pkg::OP_ADD: begin
        alu_res   = sum[31:0];
        flags_n.c = sum[32];
        flags_n.v = (op1[31] == op2[31]) && (sum[31] != op1[31]);
      end
      cpu_pkg::OP_SUB, cpu_pkg::OP_CMP: begin
        alu_res   = diff[31:0];
        flags_n.c = diff[32];  // no borrow
        flags_n.v = (op1[31] != op2[31]) && (diff[31] != op1[31]);
      end
      default: alu_res = op2;
    endcase
    flags_n.n = alu_res[31];
    flags_n.z = (alu_res == '0);
  end

  assign set_flags = fire && is_dp &&
                     (id_ex_i.inst[cpu_pkg::S_BIT] || (opcode == cpu_pkg::OP_CMP));

  // ****************************************
  // branch, memory and writeback control
  // ****************************************
  assign link_addr = id_ex_i.pc + 32'd4;
  assign target_o  = id_ex_i.pc + 32'd8 + {{6{id_ex_i.inst[23]}}, id_ex_i.inst[23:0], 2'b00};
  assign branch_o  = fire && is_br;

  assign mem_addr_full = id_ex_i.inst[cpu_pkg::U_BIT] ? op1 + {20'd0, id_ex_i.inst[11:0]}
                                                      : op1 - {20'd0, id_ex_i.inst[11:0]};
  assign mem_addr_o  = mem_addr_full[7:2];
  assign mem_we_o    = fire && is_mem && !id_ex_i.inst[cpu_pkg::L_BIT];
  assign mem_wdata_o = id_ex_i.rm_val;

  assign writes = (is_dp && (opcode != cpu_pkg::OP_CMP)) || is_ldr ||
                  (is_br && id_ex_i.inst[cpu_pkg::BL_BIT]);
  assign ex_writes_o = fire && writes;
  assign ex_dest_o   = is_br ? cpu_pkg::LINK_REG : id_ex_i.inst[cpu_pkg::RD_LSB +: 4];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      flags_r <= '0;
    end else if (set_flags) begin
      flags_r <= flags_n;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_wb_o.valid <= 1'b0;
      ex_wb_o.wb_en <= 1'b0;
    end else begin
      ex_wb_o.valid   <= id_ex_i.valid;
      ex_wb_o.wb_en   <= ex_writes_o;
      ex_wb_o.is_load <= is_ldr;
      ex_wb_o.rd      <= ex_dest_o;
      ex_wb_o.data    <= is_br ? link_addr : alu_res;  // return address for bl
    end
  end

  assign flags_o = flags_r;

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire                     clk,
  input  wire                     rst_i,
  input  wire cpu_pkg::reg_addr_t ra_i,
  input  wire cpu_pkg::reg_addr_t rb_i,
  output cpu_pkg::word_t          rdata_a_o,
  output cpu_pkg::word_t          rdata_b_o,
  input  wire cpu_pkg::reg_addr_t dbg_addr_i,
  output cpu_pkg::word_t          dbg_data_o,
  input  wire                     we_i,
  input  wire cpu_pkg::reg_addr_t wa_i,
  input  wire cpu_pkg::word_t     wd_i
);

  cpu_pkg::word_t regs [16];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[wa_i] <= wd_i;
    end
  end

  // write-through, decode sees the value retiring this cycle
  assign rdata_a_o = (we_i && (wa_i == ra_i)) ? wd_i : regs[ra_i];
  assign rdata_b_o = (we_i && (wa_i == rb_i)) ? wd_i : regs[rb_i];

  assign dbg_data_o = regs[dbg_addr_i];

endmodule

`default_nettype wire

//--- design/fetch.sv
`timescale 1ns/10ps
`default_nettype none

module fetch (
  input  wire                      clk,
  input  wire                      rst_i,
  input  wire                      stall_i,
  input  wire                      flush_i,
  input  wire                      branch_i,
  input  wire cpu_pkg::word_t      target_i,
  input  wire                      imem_we_i,
  input  wire cpu_pkg::imem_addr_t imem_addr_i,
  input  wire cpu_pkg::word_t      imem_data_i,
  output cpu_pkg::if_id_t          if_id_o
);

  cpu_pkg::word_t      imem [cpu_pkg::IMEM_DEPTH];
  cpu_pkg::word_t      pc;
  cpu_pkg::imem_addr_t pc_idx;

  assign pc_idx = pc[7:2];  // word address

  // program load port
  always_ff @(posedge clk) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc <= '0;
    end else if (branch_i) begin
      pc <= target_i;
    end else if (!stall_i) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      if_id_o.valid <= 1'b0;
    end else if (flush_i) begin
      if_id_o.valid <= 1'b0;
    end else if (!stall_i) begin
      if_id_o.valid <= 1'b1;
      if_id_o.pc    <= pc;
      if_id_o.inst  <= imem[pc_idx];
    end
  end

endmodule

`default_nettype wire

//--- design/pipeline_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_ctrl (
  input  wire                     clk,
  input  wire                     rst_i,
  input  wire cpu_pkg::if_id_t    if_id_i,
  input  wire cpu_pkg::id_ex_t    id_ex_next_i,
  input  wire cpu_pkg::reg_addr_t ex_dest_i,
  input  wire                     ex_writes_i,
  input  wire cpu_pkg::reg_addr_t src_a_i,
  input  wire cpu_pkg::reg_addr_t src_b_i,
  input  wire                     src_b_used_i,
  input  wire                     branch_i,
  output logic                    stall_o,
  output logic                    flush_o,
  output cpu_pkg::id_ex_t         id_ex_o
);

  logic [2:0] cls;
  logic [3:0] opcode;
  logic       is_dp;
  logic       src_a_used;
  logic       hit_a;
  logic       hit_b;
  logic       hazard;

  assign cls    = if_id_i.inst[cpu_pkg::CLS_LSB +: 3];
  assign opcode = if_id_i.inst[cpu_pkg::OP_LSB +: 4];
  assign is_dp  = (cls == cpu_pkg::CLS_DP_REG) || (cls == cpu_pkg::CLS_DP_IMM);

  // branches and mov never read rn, so no false stall on them
  assign src_a_used = (cls != cpu_pkg::CLS_BRANCH) && !(is_dp && (opcode == cpu_pkg::OP_MOV));

  // ****************************************
  // hazard against the writer in execute
  // ****************************************
  assign hit_a  = src_a_used && (src_a_i == ex_dest_i);
  assign hit_b  = src_b_used_i && (src_b_i == ex_dest_i);
  assign hazard = if_id_i.valid && ex_writes_i && (hit_a || hit_b);

  // a taken branch wins, the stalled instruction is discarded anyway
  assign stall_o = hazard && !branch_i;
  assign flush_o = branch_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_o.valid <= 1'b0;
    end else begin
      id_ex_o <= id_ex_next_i;
      if (hazard || branch_i) begin
        id_ex_o.valid <= 1'b0;  // bubble into execute
      end
    end
  end

endmodule

`default_nettype wire

//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // ****************************************
  // widths with a meaning
  // ****************************************
  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [5:0]  imem_addr_t;
  typedef logic [5:0]  dmem_addr_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;
  localparam reg_addr_t LINK_REG = 4'd14;  // bl return address

  // instruction field positions
  localparam int COND_LSB = 28;
  localparam int CLS_LSB  = 25;
  localparam int BL_BIT   = 24;  // link bit of the branch class
  localparam int U_BIT    = 23;  // offset up / down
  localparam int OP_LSB   = 21;
  localparam int S_BIT    = 20;
  localparam int L_BIT    = 20;  // load / store, same bit as s
  localparam int RN_LSB   = 16;
  localparam int RD_LSB   = 12;
  localparam int ROT_LSB  = 8;
  localparam int RM_LSB   = 0;

  // data processing opcodes
  localparam logic [3:0] OP_AND = 4'b0000;
  localparam logic [3:0] OP_EOR = 4'b0001;
  localparam logic [3:0] OP_SUB = 4'b0010;
  localparam logic [3:0] OP_ADD = 4'b0100;
  localparam logic [3:0] OP_CMP = 4'b1010;
  localparam logic [3:0] OP_ORR = 4'b1100;
  localparam logic [3:0] OP_MOV = 4'b1101;

  localparam logic [3:0] COND_EQ = 4'b0000;
  localparam logic [3:0] COND_NE = 4'b0001;
  localparam logic [3:0] COND_AL = 4'b1110;

  // bits 27:25
  localparam logic [2:0] CLS_DP_REG = 3'b000;
  localparam logic [2:0] CLS_DP_IMM = 3'b001;
  localparam logic [2:0] CLS_MEM    = 3'b010;
  localparam logic [2:0] CLS_BRANCH = 3'b101;

  // ****************************************
  // pipeline registers
  // ****************************************
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } if_id_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
    word_t rn_val;
    word_t rm_val;  // rd value for str
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    logic      wb_en;
    logic      is_load;
    reg_addr_t rd;
    word_t     data;
  } ex_wb_t;

endpackage

`default_nettype wire
